//--- include/gpio_defs.svh
// Build-time sizes for the GPIO UART controller
// Included by the package and by any module that needs the raw numbers

`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// -------------------------------------------------
// Pin count, works for 1 to 8
// -------------------------------------------------
`define GPIO_WIDTH 3

// -------------------------------------------------
// UART bit period in divided-clock cycles
// -------------------------------------------------
`define CYCLES_PER_BIT 8  // 16 board cycles

`endif

//--- list.f
+incdir+include
verilog/gpio_pkg.sv
verilog/gpio_bus_if.sv
verilog/baud_timer.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/command_fsm.sv
verilog/gpio_registers.sv
verilog/gpio_uart_ctrl.sv
verilog/gpio_board_top.sv
tests/tb_gpio_board.sv

//--- tests/tb_gpio_board.sv
// Directed testbench for the GPIO board wrapper
// Acts as a serial host on uart_rx/uart_tx and drives the pins per bit
`timescale 1ns/1ps

module tb_gpio_board;

  localparam int W = $bits(gpio_pkg::gpio_word_t);

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 uart_rx;
  logic                 uart_tx;
  wire gpio_pkg::gpio_word_t gpio;

  gpio_pkg::gpio_word_t drv_en;     // Testbench pin driver enables
  gpio_pkg::gpio_word_t drv_val;
  gpio_pkg::gpio_word_t model_out;  // Expected register contents
  gpio_pkg::gpio_word_t model_oe;
  int                   error_count = 0;
  int                   timeout_count = 0;

  always #2 clock = !clock;  // 4 ns board clock

  // One pin driver per bit
  for (genvar i = 0; i < W; i++) begin : g_drv
    assign gpio[i] = drv_en[i] ? drv_val[i] : 1'bz;
  end

  gpio_board_top i_dut (
    .clock   (clock),
    .reset   (reset),
    .uart_rx (uart_rx),
    .uart_tx (uart_tx),
    .gpio    (gpio)
  );

  // --------------------------------------------------
  // Expected values and compares
  // --------------------------------------------------
  // Enabled bits show the output register and the others show the external driver
  function automatic gpio_pkg::gpio_word_t resolve_pins(input gpio_pkg::gpio_word_t out_val,
                                                        input gpio_pkg::gpio_word_t oe_val,
                                                        input gpio_pkg::gpio_word_t en,
                                                        input gpio_pkg::gpio_word_t val);
    gpio_pkg::gpio_word_t res;
    for (int i = 0; i < W; i++) begin
      if (oe_val[i]) res[i] = out_val[i];
      else if (en[i]) res[i] = val[i];
      else res[i] = 1'bz;
    end
    return res;
  endfunction

  task automatic check_byte(input gpio_pkg::uart_byte_t got, input gpio_pkg::uart_byte_t expected,
                            input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s returned 8'h%02h, expected 8'h%02h",
               $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic check_pins(input gpio_pkg::gpio_word_t got,
                            input gpio_pkg::gpio_word_t expected, input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s pins are %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic check_level(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // Serial host model at 16 board cycles per bit
  // --------------------------------------------------
  task automatic send_byte(input gpio_pkg::uart_byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};  // Stop, data, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx <= frame[i];
      repeat (15) @(posedge clock);
    end
    repeat (17) @(posedge clock);  // Rest of stop bit plus one idle bit
  endtask

  task automatic receive_byte(output gpio_pkg::uart_byte_t value, output logic ok);
    int waited;
    waited = 0;
    value = '0;
    ok = 1'b0;
    @(negedge clock);
    while (uart_tx !== 1'b0 && waited < 1000) begin
      @(negedge clock);
      waited++;
    end
    if (uart_tx !== 1'b0) begin
      $display("Timeout at %0t ns: no reply start bit on uart_tx", $time);
      timeout_count++;
      return;
    end
    repeat (8) @(negedge clock);  // Middle of start bit
    if (uart_tx !== 1'b0) begin
      $display("Reply start bit on uart_tx ended before mid-bit at %0t ns", $time);
      error_count++;
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (16) @(negedge clock);
      value[i] = uart_tx;
    end
    repeat (16) @(negedge clock);
    if (uart_tx !== 1'b1) begin
      $display("Reply stop bit on uart_tx was not high at %0t ns", $time);
      error_count++;
      return;
    end
    ok = 1'b1;
  endtask

  // Model keeps only the low pin bits of the data byte
  task automatic write_reg(input gpio_pkg::opcode_t op, input gpio_pkg::uart_byte_t data);
    send_byte(op);
    send_byte(data);
    if (op == gpio_pkg::op_write_out) model_out = gpio_pkg::gpio_word_t'(data);
    else model_oe = gpio_pkg::gpio_word_t'(data);
  endtask

  task automatic read_and_check(input string what);
    gpio_pkg::uart_byte_t got;
    gpio_pkg::uart_byte_t expected;
    logic                 ok;
    expected = gpio_pkg::uart_byte_t'(resolve_pins(model_out, model_oe, drv_en, drv_val));
    fork
      send_byte(gpio_pkg::op_read_in);
      receive_byte(got, ok);
    join
    if (ok) check_byte(got, expected, what);
  endtask

  task automatic drive_pins(input gpio_pkg::gpio_word_t en, input gpio_pkg::gpio_word_t val);
    @(posedge clock);
    drv_en  <= en;
    drv_val <= val;
  endtask

  // Polls until the pins match or the wait runs out and then compares
  task automatic settle_pins(input string what);
    gpio_pkg::gpio_word_t expected;
    int                   waited;
    waited = 0;
    @(negedge clock);
    expected = resolve_pins(model_out, model_oe, drv_en, drv_val);
    while (gpio !== expected && waited < 64) begin
      @(negedge clock);
      waited++;
    end
    check_pins(gpio, expected, what);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_idle_after_reset();
    for (int i = 0; i < 64; i++) begin
      @(negedge clock);
      if (uart_tx !== 1'b1) begin
        check_level(uart_tx, 1'b1, "idle uart_tx");
        break;
      end
    end
    check_pins(gpio, 'z, "after reset");
  endtask

  task automatic test_all_outputs();
    write_reg(gpio_pkg::op_write_oe, 8'hff);
    write_reg(gpio_pkg::op_write_out, 8'h05);
    settle_pins("all enabled");
  endtask

  task automatic test_partial_enable();
    write_reg(gpio_pkg::op_write_oe, 8'h01);
    drive_pins(~model_oe, 3'b100);  // External side drives 1 and 0
    write_reg(gpio_pkg::op_write_out, 8'h03);
    settle_pins("partial enable");
    read_and_check("partial enable read");
  endtask

  task automatic test_unknown_opcode();
    send_byte(8'h00);
    send_byte(8'ha2);  // Low bits differ from the enabled output bit
    settle_pins("after unknown opcode");
    read_and_check("read after unknown opcode");
  endtask

  task automatic test_random_masks();
    gpio_pkg::uart_byte_t mask;
    gpio_pkg::uart_byte_t pattern;
    gpio_pkg::gpio_word_t ext;
    for (int n = 0; n < 20; n++) begin
      mask    = gpio_pkg::uart_byte_t'($urandom);
      pattern = gpio_pkg::uart_byte_t'($urandom);
      ext     = gpio_pkg::gpio_word_t'($urandom);
      drive_pins('0, '0);  // Release before the mask changes
      write_reg(gpio_pkg::op_write_oe, mask);
      write_reg(gpio_pkg::op_write_out, pattern);
      drive_pins(~model_oe, ext);
      settle_pins("random mask");
      read_and_check("random mask read");
    end
  endtask

  initial begin
    void'($urandom(32'hca471aed));
    reset   <= 1'b1;
    uart_rx <= 1'b1;  // Line idles high
    drv_en  <= '0;
    drv_val <= '0;
    model_out = '0;
    model_oe  = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    test_idle_after_reset();
    test_all_outputs();
    read_and_check("all enabled read");
    test_partial_enable();
    test_unknown_opcode();
    test_random_masks();

    $display("Checks done with %0d value errors and %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/baud_timer.sv
// Free-running bit timer for the UART
// A restart realigns the bit period so ticks fall relative to that cycle
`timescale 1ns/1ps
`include "gpio_defs.svh"

module baud_timer (
  input  logic clock,
  input  logic reset,
  input  logic restart,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int CNT_W = $clog2(`CYCLES_PER_BIT);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clock) begin
    if (reset || restart || bit_tick) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  assign mid_tick = (count == CNT_W'(`CYCLES_PER_BIT / 2 - 1));  // Halfway
  assign bit_tick = (count == CNT_W'(`CYCLES_PER_BIT - 1));      // End of period

  // Receiver and transmitter both rely on distinct tick cycles
  a_ticks_apart : assert property (@(posedge clock) disable iff (reset)
    !(bit_tick && mid_tick));

endmodule

//--- verilog/command_fsm.sv
// Host command parser: write_out and write_oe take one data byte,
// read_in answers with the resolved inputs; unknown opcodes are ignored
`timescale 1ns/1ps

module command_fsm (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 byte_valid,
  input  gpio_pkg::uart_byte_t byte_data,
  output logic                 tx_start,
  output gpio_pkg::uart_byte_t tx_data,
  input  logic                 tx_busy,
  gpio_bus_if.engine           bus
);

  gpio_pkg::cmd_state_t state;
  gpio_pkg::opcode_t    pending;    // Opcode waiting for its data byte
  logic                 data_ok;    // Data byte for a pending write
  logic                 reply_go;

  assign data_ok  = (state == gpio_pkg::st_wait_data) && byte_valid;
  assign reply_go = !tx_busy && !tx_start;

  // -------------------------------------------------
  // Register writes, taken the same cycle as the byte
  // -------------------------------------------------
  assign bus.write_out  = data_ok && (pending == gpio_pkg::op_write_out);
  assign bus.write_oe   = data_ok && (pending == gpio_pkg::op_write_oe);
  assign bus.write_data = gpio_pkg::gpio_word_t'(byte_data);

  // -------------------------------------------------
  // Command sequencing
  // -------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= gpio_pkg::st_idle;
      pending  <= gpio_pkg::op_write_out;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        gpio_pkg::st_idle: begin
          if (byte_valid) begin
            case (gpio_pkg::opcode_t'(byte_data))
              gpio_pkg::op_write_out,
              gpio_pkg::op_write_oe: begin
                pending <= gpio_pkg::opcode_t'(byte_data);
                state   <= gpio_pkg::st_wait_data;
              end
              gpio_pkg::op_read_in: begin
                if (reply_go) tx_start <= 1'b1;
                else state <= gpio_pkg::st_send_reply;
              end
              default: ;  // Unknown opcode, dropped
            endcase
          end
        end
        gpio_pkg::st_wait_data: begin
          if (byte_valid) state <= gpio_pkg::st_idle;
        end
        gpio_pkg::st_send_reply: begin
          // Incoming bytes are lost here
          if (reply_go) begin
            tx_start <= 1'b1;
            state    <= gpio_pkg::st_idle;
          end
        end
        default: state <= gpio_pkg::st_idle;
      endcase
    end
  end

  // Reply payload, captured with the start pulse
  always_ff @(posedge clock) begin
    tx_data <= gpio_pkg::uart_byte_t'(bus.in_value);  // Zero-extended
  end

  a_state_known : assert property (@(posedge clock) disable iff (reset)
    !$isunknown(state));

endmodule

//--- verilog/gpio_board_top.sv
// Board wrapper: halves the board clock, registers the reset button
// and resolves the bidirectional GPIO pins around the controller core
`timescale 1ns/1ps

module gpio_board_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      uart_rx,
  output logic                      uart_tx,
  inout  wire gpio_pkg::gpio_word_t gpio
);

  logic                 clock_half = 1'b0;  // Powers up low
  logic                 reset_half;
  gpio_pkg::gpio_word_t gpio_in;
  gpio_pkg::gpio_word_t gpio_oe;
  gpio_pkg::gpio_word_t gpio_out;

  always_ff @(posedge clock) begin
    clock_half <= !clock_half;
  end

  // Reset seen by the core, one flop in the slow domain
  always_ff @(posedge clock_half) begin
    reset_half <= reset;
  end

  // -------------------------------------------------
  // Per-bit pin resolution
  // -------------------------------------------------
  for (genvar i = 0; i < $bits(gpio_pkg::gpio_word_t); i++) begin : g_pin
    assign gpio[i]    = gpio_oe[i] ? gpio_out[i] : 1'bz;
    assign gpio_in[i] = gpio_oe[i] ? gpio_out[i] : gpio[i];  // Own value when driving
  end

  gpio_uart_ctrl i_ctrl (
    .clock       (clock_half),
    .reset       (reset_half),
    .uart_rx     (uart_rx),
    .uart_tx     (uart_tx),
    .gpio_input  (gpio_in),
    .gpio_oe     (gpio_oe),
    .gpio_output (gpio_out)
  );

endmodule

//--- verilog/gpio_bus_if.sv
// Register bus between the command engine and the GPIO register block
// Engine side writes, register side returns pin state
`timescale 1ns/1ps

interface gpio_bus_if;

  logic                 write_out;   // Strobe, load output register
  logic                 write_oe;    // Strobe, load enable register
  gpio_pkg::gpio_word_t write_data;
  gpio_pkg::gpio_word_t in_value;    // Synchronized pin inputs
  gpio_pkg::gpio_word_t oe_value;

  modport engine (
    output write_out, write_oe, write_data,
    input  in_value
  );

  // Register side also hands the enable mask to the pins
  modport regs (
    input  write_out, write_oe, write_data,
    output in_value, oe_value
  );

endinterface

//--- verilog/gpio_pkg.sv
// Shared types for the GPIO UART controller
// Compile ahead of every module and interface that uses them
`include "gpio_defs.svh"

package gpio_pkg;

  // Register and pin values
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  typedef logic [7:0] uart_byte_t;  // One byte on the serial link

  // Host command opcodes
  typedef enum logic [7:0] {
    op_write_out = 8'h01,
    op_write_oe  = 8'h02,
    op_read_in   = 8'h03
  } opcode_t;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_data,
    st_send_reply
  } cmd_state_t;

endpackage

//--- verilog/gpio_registers.sv
// Output and output-enable registers with the pin input synchronizer
// Both registers clear on reset so all pins start floating
`timescale 1ns/1ps

module gpio_registers (
  input  logic                 clock,
  input  logic                 reset,
  input  gpio_pkg::gpio_word_t gpio_input,
  output gpio_pkg::gpio_word_t gpio_output,
  gpio_bus_if.regs             bus
);

  gpio_pkg::gpio_word_t out_reg;
  gpio_pkg::gpio_word_t oe_reg;
  gpio_pkg::gpio_word_t in_meta;   // First synchronizer stage
  gpio_pkg::gpio_word_t in_sync;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_reg <= '0;
      oe_reg  <= '0;
    end else begin
      if (bus.write_out) out_reg <= bus.write_data;
      if (bus.write_oe) oe_reg <= bus.write_data;
    end
  end

  // Pins are asynchronous to the divided clock
  always_ff @(posedge clock) begin
    in_meta <= gpio_input;
    in_sync <= in_meta;
  end

  assign gpio_output  = out_reg;
  assign bus.oe_value = oe_reg;
  assign bus.in_value = in_sync;

  // Engine decodes one pending opcode at a time
  a_one_write : assert property (@(posedge clock) disable iff (reset)
    !(bus.write_out && bus.write_oe));

endmodule

//--- verilog/gpio_uart_ctrl.sv
// GPIO controller core driven by a host over the UART
// Pin-facing ports match a plain gpio_input / gpio_oe / gpio_output block
`timescale 1ns/1ps

module gpio_uart_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 uart_rx,
  output logic                 uart_tx,
  input  gpio_pkg::gpio_word_t gpio_input,
  output gpio_pkg::gpio_word_t gpio_oe,
  output gpio_pkg::gpio_word_t gpio_output
);

  logic                 byte_valid;
  gpio_pkg::uart_byte_t byte_data;
  logic                 tx_start;
  gpio_pkg::uart_byte_t tx_data;
  logic                 tx_busy;

  gpio_bus_if bus ();

  // -------------------------------------------------
  // Serial link
  // -------------------------------------------------
  uart_receiver i_rx (
    .clock      (clock),
    .reset      (reset),
    .rx         (uart_rx),
    .byte_valid (byte_valid),
    .byte_data  (byte_data)
  );

  uart_transmitter i_tx (
    .clock    (clock),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (uart_tx),
    .tx_busy  (tx_busy)
  );

  // -------------------------------------------------
  // Command engine and registers
  // -------------------------------------------------
  command_fsm i_fsm (
    .clock      (clock),
    .reset      (reset),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .tx_busy    (tx_busy),
    .bus        (bus.engine)
  );

  gpio_registers i_regs (
    .clock       (clock),
    .reset       (reset),
    .gpio_input  (gpio_input),
    .gpio_output (gpio_output),
    .bus         (bus.regs)
  );

  assign gpio_oe = bus.oe_value;

endmodule

//--- verilog/uart_receiver.sv
// 8N1 serial receiver, one byte_valid pulse per good frame
// Frames with a bad stop bit are dropped silently
`timescale 1ns/1ps

module uart_receiver (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   rx,
  output logic                   byte_valid,
  output gpio_pkg::uart_byte_t   byte_data
);

  logic [1:0]           rx_sync;
  logic                 rx_prev;
  logic                 busy;
  logic [3:0]           bit_cnt;   // 0 start, 1..8 data, 9 stop
  gpio_pkg::uart_byte_t data_shift;
  logic                 start_edge;
  logic                 mid_tick;
  logic                 bit_tick;

  // Bit timing restarts on each start edge
  baud_timer i_timer (
    .clock    (clock),
    .reset    (reset),
    .restart  (start_edge),
    .bit_tick (bit_tick),
    .mid_tick (mid_tick)
  );

  assign start_edge = !busy && rx_prev && !rx_sync[1];

  // -------------------------------------------------
  // Frame control
  // -------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_sync    <= 2'b11;  // Line idles high
      rx_prev    <= 1'b1;
      busy       <= 1'b0;
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      rx_sync    <= {rx_sync[0], rx};
      rx_prev    <= rx_sync[1];
      byte_valid <= 1'b0;
      if (start_edge) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy && mid_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 4'd0) begin
          busy <= !rx_sync[1];  // Glitch, not a real start bit
        end else if (bit_cnt == 4'd9) begin
          busy       <= 1'b0;
          byte_valid <= rx_sync[1];  // Stop bit must be high
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (busy && mid_tick && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
      data_shift <= {rx_sync[1], data_shift[7:1]};
    end
  end

  assign byte_data = data_shift;

endmodule

//--- verilog/uart_transmitter.sv
// 8N1 serial transmitter that shifts the LSB first
// tx_start is taken only while tx_busy is low
`timescale 1ns/1ps

module uart_transmitter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tx_start,
  input  gpio_pkg::uart_byte_t tx_data,
  output logic                 tx,
  output logic                 tx_busy
);

  logic [9:0] frame;    // Stop, data, start
  logic [3:0] bit_cnt;
  logic       bit_tick;
  logic       load;

  assign load = tx_start && !tx_busy;

  baud_timer i_timer (
    .clock    (clock),
    .reset    (reset),
    .restart  (load),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      tx_busy <= 1'b0;
      bit_cnt <= '0;
    end else if (load) begin
      tx_busy <= 1'b1;
      bit_cnt <= '0;
    end else if (tx_busy && bit_tick) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 4'd9) tx_busy <= 1'b0;  // Stop bit done
    end
  end

  always_ff @(posedge clock) begin
    if (load) frame <= {1'b1, tx_data, 1'b0};
    else if (bit_tick) frame <= {1'b1, frame[9:1]};
  end

  assign tx = !tx_busy || frame[0];  // Idle high

  // Engine must hold off while a reply is in flight
  a_no_start_busy : assert property (@(posedge clock) disable iff (reset)
    tx_start |-> !tx_busy);

endmodule
